/* project.f */
src/bru_pkg.sv
src/bru_if.sv
src/branch_compare.sv
src/branch_unit.sv
src/branch_btb.sv
src/branch_ctrl.sv
src/branch_top.sv
dv/branch_properties.sv
dv/branch_tb.sv

/* dv/branch_tb.sv */
// directed testbench for branch_top with reference rules, watchdog and per test result lines

`timescale 1ns/1ps

module branch_tb;
    import bru_pkg::*;

    // slots issued over all tests, the watchdog is sized from it
    localparam int PLANNED_SLOTS   = 37;
    localparam int WATCHDOG_CYCLES = PLANNED_SLOTS * 4 + 50;

    logic            clk_i;
    logic            rst_n_i;
    logic            issue_valid_i;
    fu_op_e          issue_op_i;
    logic [XLEN-1:0] issue_operand_a_i;
    logic [XLEN-1:0] issue_operand_b_i;
    logic [XLEN-1:0] issue_imm_i;
    logic [XLEN-1:0] issue_pc_i;
    logic            issue_compressed_i;
    logic            pred_valid_i;
    logic            pred_taken_i;
    logic [XLEN-1:0] pred_addr_i;
    logic            issue_ready_o;
    logic [XLEN-1:0] fetch_pc_i;
    logic            btb_hit_o;
    logic [XLEN-1:0] btb_target_o;
    logic            resolve_valid_o;
    logic [XLEN-1:0] resolve_pc_o;
    logic [XLEN-1:0] resolve_target_o;
    logic            resolve_taken_o;
    logic            mispredict_o;
    logic            btb_clear_o;
    logic            flush_o;
    logic [XLEN-1:0] result_o;
    logic            exc_valid_o;
    logic [3:0]      exc_cause_o;
    logic [XLEN-1:0] exc_tval_o;

    integer seed = 67668;
    int     err_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     slots_done = 0;

    // expected response of the slot currently in execute
    logic            exp_valid;
    logic            exp_taken;
    logic            exp_mis;
    logic            exp_clear;
    logic            exp_exc;
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] exp_target;
    logic [XLEN-1:0] exp_link;

    branch_top dut (.*);

    always #50 clk_i = ~clk_i;

    // hard stop in case a handshake never completes
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic show_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        $display("ERR %s got %h exp %h", name, got, exp);
        err_count++;
    endtask

    // expected outputs worked out from the resolution rules of the cluster
    task automatic model_slot(input fu_op_e op, input logic [XLEN-1:0] a, b, imm, pc,
                              input logic comp, pv, pt, input logic [XLEN-1:0] pa);
        logic            tk;
        logic [XLEN-1:0] tgt;
        case (op)
            OP_BEQ:  tk = (a == b);
            OP_BNE:  tk = (a != b);
            OP_BLT:  tk = ($signed(a) < $signed(b));
            OP_BGE:  tk = ($signed(a) >= $signed(b));
            OP_BLTU: tk = (a < b);
            OP_BGEU: tk = (a >= b);
            OP_JAL,
            OP_JALR: tk = 1'b1;
            default: tk = 1'b0;
        endcase
        tgt = ((op == OP_JALR) ? a : pc) + imm;
        if (op == OP_JALR) begin
            tgt[0] = 1'b0;
        end
        exp_link  = pc + (comp ? 64'd2 : 64'd4);
        exp_pc    = pc;
        exp_taken = 1'b0;
        exp_mis   = 1'b0;
        exp_clear = 1'b0;
        exp_exc   = 1'b0;
        exp_valid = 1'b0;
        exp_target = exp_link;
        if (op != OP_OTHER) begin
            exp_valid  = 1'b1;
            exp_taken  = tk;
            exp_target = tk ? tgt : exp_link;
            exp_exc    = tgt[0];
            // an odd target traps, otherwise compare with the front end guess
            if (!exp_exc) begin
                exp_mis = pv ? ((pt != tk) || (pt && (pa != tgt))) : tk;
            end
        end else if (pv && pt) begin
            exp_valid = 1'b1;
            exp_mis   = 1'b1;
            exp_clear = 1'b1;
        end
    endtask

    task automatic drive_slot(input fu_op_e op, input logic [XLEN-1:0] a, b, imm, pc,
                              input logic comp, pv, pt, input logic [XLEN-1:0] pa);
        issue_valid_i      = 1'b1;
        issue_op_i         = op;
        issue_operand_a_i  = a;
        issue_operand_b_i  = b;
        issue_imm_i        = imm;
        issue_pc_i         = pc;
        issue_compressed_i = comp;
        pred_valid_i       = pv;
        pred_taken_i       = pt;
        pred_addr_i        = pa;
    endtask

    // called on a falling edge with valid high, returns in the execute cycle
    task automatic wait_accept();
        int waited;
        waited = 0;
        while (!issue_ready_o && waited < 16) begin
            @(negedge clk_i);
            waited++;
        end
        if (!issue_ready_o) begin
            $display("issue slot at pc %h was never accepted", issue_pc_i);
            err_count++;
        end
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        slots_done++;
    endtask

    task automatic compare_outputs();
        if (resolve_valid_o !== exp_valid) begin
            show_mismatch("resolve_valid_o", resolve_valid_o, exp_valid);
        end
        if (mispredict_o !== exp_mis) show_mismatch("mispredict_o", mispredict_o, exp_mis);
        if (flush_o !== exp_mis) show_mismatch("flush_o", flush_o, exp_mis);
        if (exc_valid_o !== exp_exc) show_mismatch("exc_valid_o", exc_valid_o, exp_exc);
        if (result_o !== exp_link) show_mismatch("result_o", result_o, exp_link);
        if (exp_valid) begin
            if (resolve_pc_o !== exp_pc) show_mismatch("resolve_pc_o", resolve_pc_o, exp_pc);
            if (resolve_target_o !== exp_target) begin
                show_mismatch("resolve_target_o", resolve_target_o, exp_target);
            end
            if (resolve_taken_o !== exp_taken) begin
                show_mismatch("resolve_taken_o", resolve_taken_o, exp_taken);
            end
            if (btb_clear_o !== exp_clear) show_mismatch("btb_clear_o", btb_clear_o, exp_clear);
        end
        if (exp_exc) begin
            // cause code 0 is the instruction address misaligned trap
            if (exc_cause_o !== 4'd0) begin
                show_mismatch("exc_cause_o", exc_cause_o, 4'd0);
            end
            if (exc_tval_o !== exp_pc) show_mismatch("exc_tval_o", exc_tval_o, exp_pc);
        end
    endtask

    // one instruction from issue to checked resolution
    task automatic apply_slot(input fu_op_e op, input logic [XLEN-1:0] a, b, imm, pc,
                              input logic comp, pv, pt, input logic [XLEN-1:0] pa);
        model_slot(op, a, b, imm, pc, comp, pv, pt, pa);
        @(negedge clk_i);
        drive_slot(op, a, b, imm, pc, comp, pv, pt, pa);
        wait_accept();
        compare_outputs();
    endtask

    task automatic report_test(input string name, input int start_errs);
        tests_run++;
        if (err_count == start_errs) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, err_count - start_errs);
        end
    endtask

    // six conditional branches, random pairs plus equal and sign boundary pairs
    task automatic cond_branch_sweep();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
        logic [31:0]     r;
        int              start;
        start = err_count;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                a = {$random(seed), $random(seed)};
                b = {$random(seed), $random(seed)};
                if (k == 1) begin
                    b = a;
                end else if (k == 2) begin
                    a = 64'h8000_0000_0000_0000;
                    b = 64'h7fff_ffff_ffff_ffff;
                end else if (k == 3) begin
                    a = '1;
                    b = 64'd1;
                end
                pc  = {$random(seed), $random(seed)} & ~64'h1;
                r   = $random(seed);
                // even offset keeps the target aligned
                imm = {{51{r[12]}}, r[12:1], 1'b0};
                apply_slot(fu_op_e'(i), a, b, imm, pc, 1'b0, 1'b0, 1'b0, '0);
            end
        end
        report_test("conditional branches", start);
    endtask

    // correctly predicted jumps, JALR sums are odd before bit 0 is cleared
    task automatic jump_link_checks();
        int start;
        start = err_count;
        apply_slot(OP_JAL, '0, '0, 64'h100, 64'h7000, 1'b0, 1'b1, 1'b1, 64'h7100);
        apply_slot(OP_JAL, '0, '0, -64'sd16, 64'h7202, 1'b1, 1'b1, 1'b1, 64'h71f2);
        apply_slot(OP_JALR, 64'h8000_1001, '0, 64'h20, 64'h6000, 1'b0, 1'b1, 1'b1,
                   64'h8000_1020);
        apply_slot(OP_JALR, 64'h9000_0003, '0, -64'sd2, 64'h6102, 1'b1, 1'b1, 1'b1,
                   64'h9000_0000);
        report_test("jumps and link", start);
    endtask

    task automatic mispredict_cases();
        int start;
        start = err_count;
        // predicted taken, operands equal so BNE falls through
        apply_slot(OP_BNE, 64'h33, 64'h33, 64'h40, 64'h8000, 1'b0, 1'b1, 1'b1, 64'h8040);
        // right direction, predicted address off by 8
        apply_slot(OP_JAL, '0, '0, 64'h40, 64'h8100, 1'b0, 1'b1, 1'b1, 64'h8148);
        // btb claimed a branch on a plain instruction
        apply_slot(OP_OTHER, '0, '0, '0, 64'h8200, 1'b0, 1'b1, 1'b1, 64'h9000);
        report_test("prediction errors", start);
    endtask

    task automatic misaligned_targets();
        int start;
        start = err_count;
        apply_slot(OP_BEQ, 64'h5, 64'h5, 64'h11, 64'h4000, 1'b0, 1'b0, 1'b0, '0);
        apply_slot(OP_JAL, '0, '0, 64'h21, 64'h5002, 1'b1, 1'b0, 1'b0, '0);
        report_test("misaligned targets", start);
    endtask

    // second slot is held with valid high across the flush
    task automatic flush_backpressure();
        int low_cycles;
        int start;
        start = err_count;
        low_cycles = 0;
        model_slot(OP_BEQ, 64'h5, 64'h5, 64'h40, 64'h2000, 1'b0, 1'b0, 1'b0, '0);
        @(negedge clk_i);
        drive_slot(OP_BEQ, 64'h5, 64'h5, 64'h40, 64'h2000, 1'b0, 1'b0, 1'b0, '0);
        wait_accept();
        compare_outputs();
        model_slot(OP_BNE, 64'h1, 64'h2, 64'h80, 64'h3000, 1'b0, 1'b1, 1'b1, 64'h3080);
        drive_slot(OP_BNE, 64'h1, 64'h2, 64'h80, 64'h3000, 1'b0, 1'b1, 1'b1, 64'h3080);
        while (!issue_ready_o && low_cycles < 8) begin
            low_cycles++;
            @(negedge clk_i);
        end
        if (low_cycles != 2) show_mismatch("issue_ready_o low cycles", low_cycles, 2);
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        slots_done++;
        compare_outputs();
        report_test("flush back-pressure", start);
    endtask

    task automatic btb_update_clear();
        logic [XLEN-1:0] pc_br;
        int              start;
        start = err_count;
        pc_br = 64'h0000_0040_0000_0104;
        apply_slot(OP_BEQ, 64'h7, 64'h7, 64'h80, pc_br, 1'b0, 1'b1, 1'b1, pc_br + 64'h80);
        // entry is written on the edge that ends the execute cycle
        @(negedge clk_i);
        fetch_pc_i = pc_br;
        #1;
        if (btb_hit_o !== 1'b1) show_mismatch("btb_hit_o", btb_hit_o, 1'b1);
        if (btb_target_o !== pc_br + 64'h80) begin
            show_mismatch("btb_target_o", btb_target_o, pc_br + 64'h80);
        end
        // bits 3 to 1 are unchanged, so only the tag differs
        @(negedge clk_i);
        fetch_pc_i = pc_br + 64'h10;
        #1;
        if (btb_hit_o !== 1'b0) show_mismatch("btb_hit_o", btb_hit_o, 1'b0);
        apply_slot(OP_OTHER, '0, '0, '0, pc_br, 1'b0, 1'b1, 1'b1, pc_br + 64'h80);
        @(negedge clk_i);
        fetch_pc_i = pc_br;
        #1;
        if (btb_hit_o !== 1'b0) show_mismatch("btb_hit_o", btb_hit_o, 1'b0);
        report_test("btb update and clear", start);
    endtask

    initial begin
        clk_i              = 1'b0;
        rst_n_i            = 1'b0;
        issue_valid_i      = 1'b0;
        issue_op_i         = OP_OTHER;
        issue_operand_a_i  = '0;
        issue_operand_b_i  = '0;
        issue_imm_i        = '0;
        issue_pc_i         = '0;
        issue_compressed_i = 1'b0;
        pred_valid_i       = 1'b0;
        pred_taken_i       = 1'b0;
        pred_addr_i        = '0;
        fetch_pc_i         = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        // idle state straight out of reset
        if (issue_ready_o !== 1'b1) show_mismatch("issue_ready_o", issue_ready_o, 1'b1);
        if (resolve_valid_o !== 1'b0) show_mismatch("resolve_valid_o", resolve_valid_o, 1'b0);
        if (mispredict_o !== 1'b0) show_mismatch("mispredict_o", mispredict_o, 1'b0);
        if (exc_valid_o !== 1'b0) show_mismatch("exc_valid_o", exc_valid_o, 1'b0);
        if (btb_hit_o !== 1'b0) show_mismatch("btb_hit_o", btb_hit_o, 1'b0);
        cond_branch_sweep();
        jump_link_checks();
        mispredict_cases();
        misaligned_targets();
        flush_backpressure();
        btb_update_clear();
        @(negedge clk_i);
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d, slots %0d",
                 tests_run, tests_failed, err_count, dut.u_props.assert_fails, slots_done);
        if (err_count == 0 && dut.u_props.assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* dv/branch_properties.sv */
// concurrent assertions on the issue handshake and resolve outputs, bound into branch_top

`timescale 1ns/1ps

module branch_properties (
    input logic clk_i,
    input logic rst_n_i,
    input logic issue_valid_i,
    input logic issue_ready_o,
    input logic resolve_valid_o,
    input logic mispredict_o,
    input logic exc_valid_o
);

    // number of assertion failures seen so far
    int assert_fails = 0;

    // a resolution always comes from a slot accepted on the previous edge
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resolve_valid_o |-> $past(issue_valid_i && issue_ready_o))
        else begin
            $error("resolve_valid_o high without an acceptance one cycle earlier");
            assert_fails++;
        end

    // the wrong-path slot is held off while the mispredict resolves
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mispredict_o |-> !issue_ready_o)
        else begin
            $error("issue_ready_o high in a mispredict cycle");
            assert_fails++;
        end

    // and for the flush cycle after it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mispredict_o |=> !issue_ready_o)
        else begin
            $error("issue_ready_o high in the cycle after a mispredict");
            assert_fails++;
        end

    // a misaligned target traps, it never counts as a mispredict
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(exc_valid_o && mispredict_o))
        else begin
            $error("exc_valid_o and mispredict_o high together");
            assert_fails++;
        end

endmodule

bind branch_top branch_properties u_props (.*);

/* src/branch_top.sv */
// top level of the branch cluster, ctrl, compare, unit and btb tied together

`timescale 1ns/1ps

module branch_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // issue port, valid/ready
    input  logic                     issue_valid_i,
    input  bru_pkg::fu_op_e          issue_op_i,
    input  logic [bru_pkg::XLEN-1:0] issue_operand_a_i,
    input  logic [bru_pkg::XLEN-1:0] issue_operand_b_i,
    input  logic [bru_pkg::XLEN-1:0] issue_imm_i,
    input  logic [bru_pkg::XLEN-1:0] issue_pc_i,
    input  logic                     issue_compressed_i,
    input  logic                     pred_valid_i,
    input  logic                     pred_taken_i,
    input  logic [bru_pkg::XLEN-1:0] pred_addr_i,
    output logic                     issue_ready_o,
    // fetch side btb lookup
    input  logic [bru_pkg::XLEN-1:0] fetch_pc_i,
    output logic                     btb_hit_o,
    output logic [bru_pkg::XLEN-1:0] btb_target_o,
    // resolution towards fetch
    output logic                     resolve_valid_o,
    output logic [bru_pkg::XLEN-1:0] resolve_pc_o,
    output logic [bru_pkg::XLEN-1:0] resolve_target_o,
    output logic                     resolve_taken_o,
    output logic                     mispredict_o,
    output logic                     btb_clear_o,
    output logic                     flush_o,
    // link value towards writeback
    output logic [bru_pkg::XLEN-1:0] result_o,
    output logic                     exc_valid_o,
    output logic [3:0]               exc_cause_o,
    output logic [bru_pkg::XLEN-1:0] exc_tval_o
);

    bru_issue_if   issue_bus ();
    bru_resolve_if resolve_bus ();

    logic cond_taken;

    branch_ctrl u_ctrl (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .issue_valid_i      (issue_valid_i),
        .issue_op_i         (issue_op_i),
        .issue_operand_a_i  (issue_operand_a_i),
        .issue_operand_b_i  (issue_operand_b_i),
        .issue_imm_i        (issue_imm_i),
        .issue_pc_i         (issue_pc_i),
        .issue_compressed_i (issue_compressed_i),
        .pred_valid_i       (pred_valid_i),
        .pred_taken_i       (pred_taken_i),
        .pred_addr_i        (pred_addr_i),
        .issue_ready_o      (issue_ready_o),
        .issue              (issue_bus.master),
        .resolve            (resolve_bus.slave),
        .flush_o            (flush_o)
    );

    branch_compare u_compare (
        .issue   (issue_bus.slave),
        .taken_o (cond_taken)
    );

    branch_unit u_unit (
        .issue        (issue_bus.slave),
        .cond_taken_i (cond_taken),
        .resolve      (resolve_bus.master),
        .result_o     (result_o),
        .exc_valid_o  (exc_valid_o),
        .exc_cause_o  (exc_cause_o),
        .exc_tval_o   (exc_tval_o)
    );

    branch_btb u_btb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .resolve      (resolve_bus.slave),
        .lookup_pc_i  (fetch_pc_i),
        .hit_o        (btb_hit_o),
        .hit_target_o (btb_target_o)
    );

    // resolution leaves the cluster as plain ports
    assign resolve_valid_o  = resolve_bus.valid;
    assign resolve_pc_o     = resolve_bus.pc;
    assign resolve_target_o = resolve_bus.target;
    assign resolve_taken_o  = resolve_bus.is_taken;
    assign mispredict_o     = resolve_bus.is_mispredict;
    assign btb_clear_o      = resolve_bus.clear;

endmodule

/* src/branch_ctrl.sv */
// issue acceptance, execute stage register and flush state machine

`timescale 1ns/1ps

module branch_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     issue_valid_i,
    input  bru_pkg::fu_op_e          issue_op_i,
    input  logic [bru_pkg::XLEN-1:0] issue_operand_a_i,
    input  logic [bru_pkg::XLEN-1:0] issue_operand_b_i,
    input  logic [bru_pkg::XLEN-1:0] issue_imm_i,
    input  logic [bru_pkg::XLEN-1:0] issue_pc_i,
    input  logic                     issue_compressed_i,
    input  logic                     pred_valid_i,
    input  logic                     pred_taken_i,
    input  logic [bru_pkg::XLEN-1:0] pred_addr_i,
    output logic                     issue_ready_o,
    bru_issue_if.master              issue,
    bru_resolve_if.slave             resolve,
    output logic                     flush_o
);
    import bru_pkg::*;

    ctrl_state_e     state_q;
    ctrl_state_e     state_d;
    logic            mispredict;
    logic            accept;
    logic            exe_valid_q;
    fu_op_e          exe_op_q;
    logic [XLEN-1:0] exe_operand_a_q;
    logic [XLEN-1:0] exe_operand_b_q;
    logic [XLEN-1:0] exe_imm_q;
    logic [XLEN-1:0] exe_pc_q;
    logic            exe_compressed_q;
    logic            exe_pred_valid_q;
    logic            exe_pred_taken_q;
    logic [XLEN-1:0] exe_pred_addr_q;

    assign mispredict = resolve.valid && resolve.is_mispredict;

    // the slot behind a mispredict is on the wrong path, so hold it off
    // now and for the flush cycle that follows
    assign issue_ready_o = (state_q == ST_RUN) && !mispredict;
    assign accept        = issue_valid_i && issue_ready_o;

    // front end redirects in the same cycle the mispredict resolves
    assign flush_o = mispredict;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN:   if (mispredict) state_d = ST_FLUSH;
            ST_FLUSH: state_d = ST_RUN;
            default:  state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_RUN;
            exe_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // execute empties whenever nothing is accepted
            exe_valid_q <= accept;
        end
    end

    // payload only moves on acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            exe_op_q         <= issue_op_i;
            exe_operand_a_q  <= issue_operand_a_i;
            exe_operand_b_q  <= issue_operand_b_i;
            exe_imm_q        <= issue_imm_i;
            exe_pc_q         <= issue_pc_i;
            exe_compressed_q <= issue_compressed_i;
            exe_pred_valid_q <= pred_valid_i;
            exe_pred_taken_q <= pred_taken_i;
            exe_pred_addr_q  <= pred_addr_i;
        end
    end

    // execute stage feeds the compare and resolve logic
    assign issue.valid         = exe_valid_q;
    assign issue.op            = exe_op_q;
    assign issue.operand_a     = exe_operand_a_q;
    assign issue.operand_b     = exe_operand_b_q;
    assign issue.imm           = exe_imm_q;
    assign issue.pc            = exe_pc_q;
    assign issue.is_compressed = exe_compressed_q;
    assign issue.pred_valid    = exe_pred_valid_q;
    assign issue.pred_taken    = exe_pred_taken_q;
    assign issue.pred_addr     = exe_pred_addr_q;

endmodule

/* src/branch_btb.sv */
// direct-mapped branch target buffer with combinational lookup and write on resolve

`timescale 1ns/1ps

module branch_btb (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    bru_resolve_if.slave             resolve,
    input  logic [bru_pkg::XLEN-1:0] lookup_pc_i,
    output logic                     hit_o,
    output logic [bru_pkg::XLEN-1:0] hit_target_o
);
    import bru_pkg::*;

    btb_entry_t           btb_q [BTB_ENTRIES];
    btb_entry_t           lookup_entry;
    logic [BTB_IDX_W-1:0] lookup_idx;
    logic [BTB_IDX_W-1:0] update_idx;
    logic                 write_en;
    logic                 clear_en;

    // fetch side read, same cycle
    assign lookup_idx   = lookup_pc_i[BTB_IDX_W:1];
    assign lookup_entry = btb_q[lookup_idx];
    assign hit_o        = lookup_entry.valid &&
                          (lookup_entry.tag == lookup_pc_i[XLEN-1:BTB_IDX_W+1]);
    assign hit_target_o = lookup_entry.target;

    // only taken control flow earns an entry
    assign update_idx = resolve.pc[BTB_IDX_W:1];
    assign clear_en   = resolve.valid && resolve.clear;
    assign write_en   = resolve.valid && resolve.is_branch && resolve.is_taken && !resolve.clear;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_q[i] <= '0;
            end
        end else if (clear_en) begin
            // whatever sits at that index is dropped, tag is not checked
            btb_q[update_idx].valid <= 1'b0;
        end else if (write_en) begin
            btb_q[update_idx].valid  <= 1'b1;
            btb_q[update_idx].tag    <= resolve.pc[XLEN-1:BTB_IDX_W+1];
            btb_q[update_idx].target <= resolve.target;
        end
    end

endmodule

/* src/branch_unit.sv */
// target and link calculation, mispredict detection and misaligned target exception

`timescale 1ns/1ps

module branch_unit (
    bru_issue_if.slave               issue,
    input  logic                     cond_taken_i,
    bru_resolve_if.master            resolve,
    output logic [bru_pkg::XLEN-1:0] result_o,
    output logic                     exc_valid_o,
    output logic [3:0]               exc_cause_o,
    output logic [bru_pkg::XLEN-1:0] exc_tval_o
);
    import bru_pkg::*;

    logic            is_cf;
    logic            cf_valid;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] link_pc;

    // anything from BEQ up to JALR counts as control flow
    assign is_cf    = issue.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                                       OP_BLTU, OP_BGEU, OP_JAL, OP_JALR};
    assign cf_valid = issue.valid && is_cf;

    // JALR jumps relative to rs1, everything else relative to its own pc
    assign jump_base = (issue.op == OP_JALR) ? issue.operand_a : issue.pc;

    // fall-through address depends on the instruction length
    assign link_pc = issue.pc + (issue.is_compressed ? XLEN'(2) : XLEN'(4));

    always_comb begin
        // plain addition, imm is already sign extended
        jump_target = jump_base + issue.imm;
        // JALR drops the lowest bit of the sum
        if (issue.op == OP_JALR) begin
            jump_target[0] = 1'b0;
        end
    end

    // the link value goes to writeback whether or not it is used
    assign result_o = link_pc;

    always_comb begin
        resolve.valid         = 1'b0;
        resolve.pc            = issue.pc;
        resolve.target        = link_pc;
        resolve.is_taken      = 1'b0;
        resolve.is_mispredict = 1'b0;
        resolve.clear         = 1'b0;
        resolve.is_branch     = cf_valid;

        if (cf_valid) begin
            resolve.valid    = 1'b1;
            resolve.is_taken = cond_taken_i;
            // not taken branches continue at the next sequential pc
            resolve.target   = cond_taken_i ? jump_target : link_pc;
            // an odd target traps instead, so it never counts as a mispredict
            if (!jump_target[0]) begin
                if (issue.pred_valid) begin
                    // wrong direction
                    if (issue.pred_taken != cond_taken_i) begin
                        resolve.is_mispredict = 1'b1;
                    end
                    // right direction but the front end went somewhere else
                    if (issue.pred_taken && (issue.pred_addr != jump_target)) begin
                        resolve.is_mispredict = 1'b1;
                    end
                end else if (cond_taken_i) begin
                    // fetch ran on sequentially, a taken jump redirects it
                    resolve.is_mispredict = 1'b1;
                end
            end
        end else if (issue.valid && issue.pred_valid && issue.pred_taken) begin
            // the btb guessed a branch where there is none
            // fetch goes back to the fall-through and the entry gets dropped
            resolve.valid         = 1'b1;
            resolve.is_mispredict = 1'b1;
            resolve.clear         = 1'b1;
            resolve.target        = link_pc;
        end
    end

    // targets need 2 byte alignment, tval carries the faulting pc
    assign exc_valid_o = cf_valid && jump_target[0];
    assign exc_cause_o = EXC_INSTR_MISALIGNED;
    assign exc_tval_o  = issue.pc;

endmodule

/* src/branch_compare.sv */
// operand comparison that produces the branch condition for every operator

`timescale 1ns/1ps

module branch_compare (
    bru_issue_if.slave issue,
    output logic       taken_o
);
    import bru_pkg::*;

    logic equal;
    logic less_s;
    logic less_u;

    // three base comparisons, the rest are their inverses
    assign equal  = (issue.operand_a == issue.operand_b);
    assign less_s = ($signed(issue.operand_a) < $signed(issue.operand_b));
    assign less_u = (issue.operand_a < issue.operand_b);

    always_comb begin
        case (issue.op)
            OP_BEQ:  taken_o = equal;
            OP_BNE:  taken_o = !equal;
            OP_BLT:  taken_o = less_s;
            OP_BGE:  taken_o = !less_s;
            OP_BLTU: taken_o = less_u;
            OP_BGEU: taken_o = !less_u;
            // jumps are unconditional
            OP_JAL,
            OP_JALR: taken_o = 1'b1;
            // non control flow never redirects fetch
            default: taken_o = 1'b0;
        endcase
    end

endmodule

/* src/bru_if.sv */
// issue interface and resolve interface of the branch cluster, each with master and slave modports

`timescale 1ns/1ps

interface bru_issue_if;
    import bru_pkg::*;

    // one instruction sitting in the execute stage
    logic            valid;
    fu_op_e          op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    // imm arrives already sign extended to the full width
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            is_compressed;
    // what the front end guessed for this slot
    logic            pred_valid;
    logic            pred_taken;
    logic [XLEN-1:0] pred_addr;

    modport master (
        output valid, op, operand_a, operand_b, imm, pc,
        output is_compressed, pred_valid, pred_taken, pred_addr
    );

    modport slave (
        input valid, op, operand_a, operand_b, imm, pc,
        input is_compressed, pred_valid, pred_taken, pred_addr
    );
endinterface

interface bru_resolve_if;
    import bru_pkg::*;

    // resolution of the slot in execute, valid for one cycle
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            is_taken;
    logic            is_mispredict;
    // set when the btb entry for pc has to be dropped
    logic            clear;
    // high only for real control flow instructions
    logic            is_branch;

    modport master (
        output valid, pc, target, is_taken, is_mispredict, clear, is_branch
    );

    modport slave (
        input valid, pc, target, is_taken, is_mispredict, clear, is_branch
    );
endinterface

/* src/bru_pkg.sv */
// shared widths, operator and control state enums, exception cause code and btb entry type

package bru_pkg;

    // datapath width of the core
    localparam int XLEN = 64;

    // direct-mapped btb geometry, the index comes from pc bits 3 to 1
    localparam int BTB_ENTRIES = 8;
    localparam int BTB_IDX_W   = 3;
    // the tag keeps every pc bit above the index, bit 0 is always zero
    localparam int BTB_TAG_W   = XLEN - BTB_IDX_W - 1;

    // functional unit operators seen on the issue port
    // OP_OTHER stands for any instruction that is not control flow
    typedef enum logic [3:0] {
        OP_BEQ   = 4'd0,
        OP_BNE   = 4'd1,
        OP_BLT   = 4'd2,
        OP_BGE   = 4'd3,
        OP_BLTU  = 4'd4,
        OP_BGEU  = 4'd5,
        OP_JAL   = 4'd6,
        OP_JALR  = 4'd7,
        OP_OTHER = 4'd8
    } fu_op_e;

    // issue control, flush holds ready low for one extra cycle
    typedef enum logic {
        ST_RUN   = 1'b0,
        ST_FLUSH = 1'b1
    } ctrl_state_e;

    // instruction address misaligned cause code
    localparam logic [3:0] EXC_INSTR_MISALIGNED = 4'd0;

    // one btb line
    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

endpackage
